// File: logic/gb_io_pkg.sv
// system i/o shared definitions
package gb_io_pkg;

	//--------------------------------------------------------------------------
	// register map
	//--------------------------------------------------------------------------
	localparam logic [15:0] ADDR_JOYP = 16'hff00;   // P1 joypad row select
	localparam logic [15:0] ADDR_IF   = 16'hff0f;   // interrupt flags
	localparam logic [15:0] ADDR_IE   = 16'hffff;   // interrupt enable
	localparam logic [15:0] ADDR_KEY1 = 16'hff4d;   // speed switch, cgb only
	localparam logic [15:0] ADDR_VBK  = 16'hff4f;   // vram bank, cgb only
	localparam logic [15:0] ADDR_BOOT = 16'hff50;   // boot rom disable
	localparam logic [15:0] ADDR_SVBK = 16'hff70;   // wram bank, cgb only

	//--------------------------------------------------------------------------
	// interrupts
	//--------------------------------------------------------------------------
	// vblank, lcd stat, timer, serial, joypad
	localparam int          IRQ_COUNT    = 5;
	localparam logic [7:0]  IRQ_VEC_BASE = 8'h40;  // rst vector of bit 0
	localparam logic [7:0]  IRQ_VEC_STEP = 8'h08;

	//--------------------------------------------------------------------------
	// reset values and keys
	//--------------------------------------------------------------------------
	localparam logic [2:0]  IRAM_BANK_RESET = 3'd1;   // bank 0 is never mapped at d000
	localparam logic [7:0]  BOOT_KEY_GBC    = 8'h11;  // value the cgb bios writes
	localparam logic [7:0]  OPEN_BUS        = 8'hff;

	// FF50 write byte, compared whole in cgb mode
	// mono mode only looks at bit 0
	typedef struct packed {
		logic [6:0] unused;
		logic       lock;      // 1 = unmap boot rom
	} boot_ctl_bits_t;

	typedef union packed {
		logic [7:0]     raw;    // whole byte view
		boot_ctl_bits_t f;      // field view
	} boot_ctl_u;

endpackage

// File: logic/irq_bus_if.sv
// decoder to interrupt controller bus
interface irq_bus_if;

	logic       sel_if;    // FF0F hit
	logic       sel_ie;    // FFFF hit
	logic       wr_stb;    // first ce edge of a write pulse
	logic [7:0] wdata;
	logic [7:0] rdata;     // IF or IE, comb
	logic       irq_ack;   // m1 + iorq both low
	logic [7:0] irq_vec;   // rst address of winning source

	modport decoder (
		output sel_if, sel_ie, wr_stb, wdata,
		input  rdata, irq_ack, irq_vec
	);

	modport regs (
		input  sel_if, sel_ie, wr_stb, wdata,
		output rdata, irq_ack, irq_vec
	);

endinterface

// File: logic/ctrl_bus_if.sv
// decoder to system control bus
interface ctrl_bus_if;

	// selects arrive already mode gated
	logic       sel_joy;
	logic       sel_svbk;
	logic       sel_vbk;
	logic       sel_key1;
	logic       sel_boot;
	logic       wr_stb;
	logic [7:0] wdata;
	logic [7:0] rdata;

	modport decoder (
		output sel_joy, sel_svbk, sel_vbk, sel_key1, sel_boot, wr_stb, wdata,
		input  rdata
	);

	modport regs (
		input  sel_joy, sel_svbk, sel_vbk, sel_key1, sel_boot, wr_stb, wdata,
		output rdata
	);

endinterface

// File: logic/irq_controller.sv
// interrupt controller
module irq_controller (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce,
	input  logic       cpu_m1_n,
	input  logic       cpu_iorq_n,
	input  logic       vblank_evt,
	input  logic       lcd_evt,
	input  logic       timer_evt,
	input  logic       serial_evt,
	input  logic [3:0] joy_din,
	output logic       irq_n,
	irq_bus_if.regs    bus
);
	import gb_io_pkg::*;

	logic [IRQ_COUNT-1:0] if_r;       // pending flags
	logic [7:0]           ie_r;       // all 8 bits r/w, only low 5 matter
	logic [IRQ_COUNT-2:0] evt;
	logic [IRQ_COUNT-2:0] evt_d;      // previous sample of the event lines
	logic [3:0]           joy_d1;
	logic [3:0]           joy_d2;
	logic                 joy_fall;
	logic                 ack_d;      // ack phase seen at last ce edge
	logic [IRQ_COUNT-1:0] pending;
	logic [IRQ_COUNT-1:0] if_set;
	logic [IRQ_COUNT-1:0] if_clr;
	logic [2:0]           irq_idx;
	logic                 irq_any;

	//--------------------------------------------------------------------------
	// event edges
	//--------------------------------------------------------------------------
	assign evt      = {serial_evt, timer_evt, lcd_evt, vblank_evt}; // IF bit order
	assign joy_fall = |(~joy_d1 & joy_d2);  // any P10..P13 going low
	assign if_set   = {joy_fall, evt & ~evt_d};

	//--------------------------------------------------------------------------
	// priority, lowest bit wins
	//--------------------------------------------------------------------------
	assign pending = if_r & ie_r[IRQ_COUNT-1:0];

	always_comb begin
		irq_idx = '0;
		irq_any = 1'b0;
		// walk down so the lowest set bit is the last one kept
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (pending[i]) begin
				irq_idx = 3'(i);
				irq_any = 1'b1;
			end
		end
	end

	assign bus.irq_ack = ~cpu_m1_n & ~cpu_iorq_n;
	assign bus.irq_vec = irq_any ? IRQ_VEC_BASE + IRQ_VEC_STEP * 8'(irq_idx) : 8'h00;
	assign irq_n       = ~irq_any;  // low while anything pending and enabled

	// clear only on the edge right after the ack phase drops
	assign if_clr = (ack_d && !bus.irq_ack && irq_any) ?
		IRQ_COUNT'(1) << irq_idx : '0;

	// upper three IF bits are unimplemented, read as 1
	assign bus.rdata = bus.sel_if ? {3'b111, if_r} :
		bus.sel_ie ? ie_r : 8'h00;

	//--------------------------------------------------------------------------
	// IF / IE
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r   <= '0;
			ie_r   <= '0;
			evt_d  <= '0;
			joy_d1 <= '0;
			joy_d2 <= '0;
			ack_d  <= 1'b0;
		end else if (ce) begin
			evt_d  <= evt;
			joy_d1 <= joy_din;       // two stage, catches the fall one clock late
			joy_d2 <= joy_d1;
			ack_d  <= bus.irq_ack;
			if_r   <= (if_r | if_set) & ~if_clr;
			// cpu writes come last so they win over set and clear
			if (bus.wr_stb && bus.sel_ie)
				ie_r <= bus.wdata;
			if (bus.wr_stb && bus.sel_if)
				if_r <= bus.wdata[IRQ_COUNT-1:0];
		end
	end

endmodule

// File: logic/sys_ctrl_regs.sv
// system control registers
module sys_ctrl_regs (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce,
	input  logic       is_gbc,
	input  logic       cpu_stop,
	input  logic [3:0] joy_din,
	output logic [1:0] joy_p54,
	output logic [2:0] iram_bank,
	output logic       vram_bank,
	output logic       speed,
	output logic       boot_rom_enabled,
	ctrl_bus_if.regs   bus
);
	import gb_io_pkg::*;

	logic      prepare;      // KEY1 bit 0, armed for the next stop
	logic      wr;
	boot_ctl_u boot_wr;
	logic      boot_unlock;

	assign wr      = ce & bus.wr_stb;
	assign boot_wr = bus.wdata;

	// cgb bios writes 11h, dmg bios just sets bit 0
	assign boot_unlock = is_gbc ? (boot_wr.raw == BOOT_KEY_GBC) : boot_wr.f.lock;

	//--------------------------------------------------------------------------
	// joypad, banks, boot rom
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54          <= 2'b00;
			iram_bank        <= IRAM_BANK_RESET;
			vram_bank        <= 1'b0;
			boot_rom_enabled <= 1'b1;
		end else if (wr) begin
			if (bus.sel_joy)
				joy_p54 <= bus.wdata[5:4];     // only the row selects are writable
			if (bus.sel_svbk)
				iram_bank <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0]; // 0 -> 1
			if (bus.sel_vbk)
				vram_bank <= bus.wdata[0];
			if (bus.sel_boot && boot_unlock)
				boot_rom_enabled <= 1'b0;       // one way until next reset
		end
	end

	//--------------------------------------------------------------------------
	// speed switch
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed   <= 1'b0;
			prepare <= 1'b0;
		end else if (ce) begin
			if (bus.wr_stb && bus.sel_key1)
				prepare <= bus.wdata[0];
			// stop with prepare armed flips the speed
			if (is_gbc && prepare && cpu_stop) begin
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	//--------------------------------------------------------------------------
	// readback
	//--------------------------------------------------------------------------
	always_comb begin
		bus.rdata = 8'h00;   // decoder ignores it when nothing here is hit
		if (bus.sel_joy)
			bus.rdata = {2'b11, joy_p54, joy_din};     // live button lines
		else if (bus.sel_svbk)
			bus.rdata = {5'h1f, iram_bank};
		else if (bus.sel_vbk)
			bus.rdata = {7'h7f, vram_bank};
		else if (bus.sel_key1)
			bus.rdata = {speed, 6'h3f, prepare};
	end

endmodule

// File: logic/cpu_bus_decode.sv
// cpu bus decoder
module cpu_bus_decode (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  logic        is_gbc,
	input  logic        is_gbc_game,
	input  logic        boot_rom_enabled,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_wr_n,
	output logic [7:0]  cpu_rdata,
	irq_bus_if.decoder  irq,
	ctrl_bus_if.decoder ctrl
);
	import gb_io_pkg::*;

	logic wr_n_d;     // cpu_wr_n at the previous ce edge
	logic wr_stb;
	logic irq_hit;
	logic ctrl_hit;

	//--------------------------------------------------------------------------
	// write strobe
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			wr_n_d <= 1'b1;
		else if (ce)
			wr_n_d <= cpu_wr_n;
	end

	// high only until the first ce edge of the low pulse
	assign wr_stb = ~cpu_wr_n & wr_n_d;

	assign irq.wr_stb  = wr_stb;
	assign irq.wdata   = cpu_wdata;
	assign ctrl.wr_stb = wr_stb;
	assign ctrl.wdata  = cpu_wdata;

	//--------------------------------------------------------------------------
	// address decode, all mode gating sits here
	//--------------------------------------------------------------------------
	assign irq.sel_if   = (cpu_addr == ADDR_IF);
	assign irq.sel_ie   = (cpu_addr == ADDR_IE);
	assign ctrl.sel_joy = (cpu_addr == ADDR_JOYP);
	assign ctrl.sel_boot = (cpu_addr == ADDR_BOOT);
	assign ctrl.sel_vbk = is_gbc && (cpu_addr == ADDR_VBK);
	// svbk also reachable while the cgb bios runs a dmg cart
	assign ctrl.sel_svbk = is_gbc && (is_gbc_game || boot_rom_enabled) &&
		(cpu_addr == ADDR_SVBK);
	assign ctrl.sel_key1 = is_gbc && is_gbc_game && (cpu_addr == ADDR_KEY1);

	//--------------------------------------------------------------------------
	// read mux
	//--------------------------------------------------------------------------
	assign irq_hit  = irq.sel_if | irq.sel_ie;
	// FF50 is write only, falls through to open bus
	assign ctrl_hit = ctrl.sel_joy | ctrl.sel_svbk | ctrl.sel_vbk | ctrl.sel_key1;

	always_comb begin
		if (irq.irq_ack)
			cpu_rdata = irq.irq_vec;    // vector fetch beats any address
		else if (irq_hit)
			cpu_rdata = irq.rdata;
		else if (ctrl_hit)
			cpu_rdata = ctrl.rdata;
		else
			cpu_rdata = OPEN_BUS;
	end

endmodule

// File: logic/gb_io_top.sv
// system i/o register block
module gb_io_top (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  logic        is_gbc,
	input  logic        is_gbc_game,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rd_n,      // reads are comb, strobe not needed
	input  logic        cpu_wr_n,
	input  logic        cpu_m1_n,
	input  logic        cpu_iorq_n,
	input  logic        cpu_stop,
	input  logic        vblank_evt,
	input  logic        lcd_evt,
	input  logic        timer_evt,
	input  logic        serial_evt,
	input  logic [3:0]  joy_din,
	output logic [7:0]  cpu_rdata,
	output logic        irq_n,
	output logic [1:0]  joy_p54,
	output logic [2:0]  iram_bank,
	output logic        vram_bank,
	output logic        speed,
	output logic        boot_rom_enabled
);

	irq_bus_if  irq_bus ();
	ctrl_bus_if ctrl_bus ();

	cpu_bus_decode i_decode (
		.clk_sys          (clk_sys),
		.reset_ss         (reset_ss),
		.ce               (ce),
		.is_gbc           (is_gbc),
		.is_gbc_game      (is_gbc_game),
		.boot_rom_enabled (boot_rom_enabled),
		.cpu_addr         (cpu_addr),
		.cpu_wdata        (cpu_wdata),
		.cpu_wr_n         (cpu_wr_n),
		.cpu_rdata        (cpu_rdata),
		.irq              (irq_bus.decoder),
		.ctrl             (ctrl_bus.decoder)
	);

	irq_controller i_irq (
		.clk_sys    (clk_sys),
		.reset_ss   (reset_ss),
		.ce         (ce),
		.cpu_m1_n   (cpu_m1_n),
		.cpu_iorq_n (cpu_iorq_n),
		.vblank_evt (vblank_evt),
		.lcd_evt    (lcd_evt),
		.timer_evt  (timer_evt),
		.serial_evt (serial_evt),
		.joy_din    (joy_din),
		.irq_n      (irq_n),
		.bus        (irq_bus.regs)
	);

	sys_ctrl_regs i_ctrl (
		.clk_sys          (clk_sys),
		.reset_ss         (reset_ss),
		.ce               (ce),
		.is_gbc           (is_gbc),
		.cpu_stop         (cpu_stop),
		.joy_din          (joy_din),
		.joy_p54          (joy_p54),
		.iram_bank        (iram_bank),
		.vram_bank        (vram_bank),
		.speed            (speed),
		.boot_rom_enabled (boot_rom_enabled),
		.bus              (ctrl_bus.regs)
	);

endmodule

// File: sim/tb_gb_io.sv
// system i/o block testbench
module tb_gb_io;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_MODE = 0;   // data[1] is_gbc, data[0] is_gbc_game
	localparam int OP_RST  = 1;
	localparam int OP_WR   = 2;
	localparam int OP_RD   = 3;   // exp = cpu_rdata
	localparam int OP_EVT  = 4;   // data[3:0] serial, timer, lcd, vblank
	localparam int OP_ACK  = 5;   // exp = vector on the bus
	localparam int OP_STOP = 6;
	localparam int OP_JOY  = 7;   // data[3:0] new button lines
	localparam int OP_PORT = 8;   // exp from port_word()

	typedef struct packed {
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [15:0] exp;
	} row_t;

	logic        clk_sys     = 1'b0;
	logic        reset_ss    = 1'b0;
	logic        ce          = 1'b1;   // full rate throughout
	logic        is_gbc      = 1'b0;
	logic        is_gbc_game = 1'b0;
	logic [15:0] cpu_addr    = 16'h0000;
	logic [7:0]  cpu_wdata   = 8'h00;
	logic        cpu_rd_n    = 1'b1;
	logic        cpu_wr_n    = 1'b1;
	logic        cpu_m1_n    = 1'b1;
	logic        cpu_iorq_n  = 1'b1;
	logic        cpu_stop    = 1'b0;
	logic [3:0]  evt         = 4'h0;
	logic [3:0]  joy_din     = 4'hf;   // buttons released
	logic [7:0]  cpu_rdata;
	logic        irq_n;
	logic [1:0]  joy_p54;
	logic [2:0]  iram_bank;
	logic        vram_bank;
	logic        speed;
	logic        boot_rom_enabled;
	row_t        rows[$];
	int          errors = 0;

	always #50 clk_sys = ~clk_sys;

	gb_io_top i_dut (
		.clk_sys (clk_sys), .reset_ss (reset_ss), .ce (ce),
		.is_gbc (is_gbc), .is_gbc_game (is_gbc_game),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata), .cpu_rd_n (cpu_rd_n),
		.cpu_wr_n (cpu_wr_n), .cpu_m1_n (cpu_m1_n), .cpu_iorq_n (cpu_iorq_n),
		.cpu_stop (cpu_stop), .vblank_evt (evt[0]), .lcd_evt (evt[1]),
		.timer_evt (evt[2]), .serial_evt (evt[3]), .joy_din (joy_din),
		.cpu_rdata (cpu_rdata), .irq_n (irq_n), .joy_p54 (joy_p54),
		.iram_bank (iram_bank), .vram_bank (vram_bank), .speed (speed),
		.boot_rom_enabled (boot_rom_enabled)
	);

	// inputs change 5 ns past the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [15:0] port_word(input logic irq, input logic [1:0] p54,
		input logic [2:0] bank, input logic vbk, input logic spd, input logic boot);
		return 16'({irq, p54, bank, vbk, spd, boot});
	endfunction

	task automatic add(input int op, input logic [15:0] addr, input logic [7:0] data,
		input logic [15:0] exp);
		rows.push_back({4'(op), addr, data, exp});
	endtask

	//--------------------------------------------------------------------------
	// stimulus table, expected values from the register map rules
	//--------------------------------------------------------------------------
	task automatic build_table();
		add(OP_MODE, 16'h0, 8'h03, 16'h0);    // cgb console, cgb game
		add(OP_RST,  16'h0, 8'h00, 16'h0);
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b00, 3'd1, 0, 0, 1));
		add(OP_RD, 16'hff00, 8'h00, 16'h00cf);  // 11, p54 0, buttons f
		add(OP_RD, 16'hff0f, 8'h00, 16'h00e0);
		add(OP_RD, 16'hffff, 8'h00, 16'h0000);
		add(OP_RD, 16'hff4d, 8'h00, 16'h007e);
		add(OP_RD, 16'hff4f, 8'h00, 16'h00fe);
		add(OP_RD, 16'hff50, 8'h00, 16'h00ff);  // write only
		add(OP_RD, 16'hff70, 8'h00, 16'h00f9);
		add(OP_RD, 16'hff80, 8'h00, 16'h00ff);  // unmapped
		add(OP_WR, 16'hff70, 8'h03, 16'h0);
		add(OP_RD, 16'hff70, 8'h00, 16'h00fb);
		add(OP_WR, 16'hff70, 8'h00, 16'h0);     // bank 0 maps to 1
		add(OP_RD, 16'hff70, 8'h00, 16'h00f9);
		add(OP_WR, 16'hff4f, 8'h01, 16'h0);
		add(OP_RD, 16'hff4f, 8'h00, 16'h00ff);
		// mono mode, cgb registers vanish
		add(OP_MODE, 16'h0, 8'h00, 16'h0);
		add(OP_RD, 16'hff70, 8'h00, 16'h00ff);
		add(OP_RD, 16'hff4f, 8'h00, 16'h00ff);
		add(OP_RD, 16'hff4d, 8'h00, 16'h00ff);
		add(OP_WR, 16'hff70, 8'h05, 16'h0);
		add(OP_WR, 16'hff4f, 8'h00, 16'h0);
		add(OP_WR, 16'hff4d, 8'h01, 16'h0);
		add(OP_MODE, 16'h0, 8'h03, 16'h0);
		add(OP_RD, 16'hff70, 8'h00, 16'h00f9);
		add(OP_RD, 16'hff4f, 8'h00, 16'h00ff);
		add(OP_RD, 16'hff4d, 8'h00, 16'h007e);
		// timer + vblank, vblank wins first
		add(OP_WR, 16'hffff, 8'h1f, 16'h0);
		add(OP_EVT,  16'h0, 8'h05, 16'h0);
		add(OP_PORT, 16'h0, 8'h00, port_word(0, 2'b00, 3'd1, 1, 0, 1));
		add(OP_RD, 16'hff0f, 8'h00, 16'h00e5);
		add(OP_ACK,  16'h0, 8'h00, 16'h0040);
		add(OP_RD, 16'hff0f, 8'h00, 16'h00e4);  // only bit 0 gone
		add(OP_ACK,  16'h0, 8'h00, 16'h0050);
		add(OP_RD, 16'hff0f, 8'h00, 16'h00e0);
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b00, 3'd1, 1, 0, 1));
		// joypad
		add(OP_JOY,  16'h0, 8'h0e, 16'h0);      // P10 pressed
		add(OP_RD, 16'hff0f, 8'h00, 16'h00f0);
		add(OP_WR, 16'hff00, 8'h20, 16'h0);
		add(OP_RD, 16'hff00, 8'h00, 16'h00ee);
		add(OP_PORT, 16'h0, 8'h00, port_word(0, 2'b10, 3'd1, 1, 0, 1));
		add(OP_JOY,  16'h0, 8'h0f, 16'h0);
		add(OP_WR, 16'hff0f, 8'h00, 16'h0);
		// speed switch
		add(OP_WR, 16'hff4d, 8'h01, 16'h0);
		add(OP_RD, 16'hff4d, 8'h00, 16'h007f);
		add(OP_STOP, 16'h0, 8'h00, 16'h0);
		add(OP_RD, 16'hff4d, 8'h00, 16'h00fe);  // speed up, prepare gone
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b10, 3'd1, 1, 1, 1));
		// boot rom unmap, mono then cgb
		add(OP_MODE, 16'h0, 8'h00, 16'h0);
		add(OP_WR, 16'hff50, 8'h01, 16'h0);
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b10, 3'd1, 1, 1, 0));
		add(OP_MODE, 16'h0, 8'h03, 16'h0);
		add(OP_RST,  16'h0, 8'h00, 16'h0);
		add(OP_WR, 16'hff50, 8'h01, 16'h0);    // wrong key in cgb mode
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b00, 3'd1, 0, 0, 1));
		add(OP_WR, 16'hff50, 8'h11, 16'h0);
		add(OP_PORT, 16'h0, 8'h00, port_word(1, 2'b00, 3'd1, 0, 0, 0));
	endtask

	//--------------------------------------------------------------------------
	// one row, starts and ends 5 ns past an edge
	//--------------------------------------------------------------------------
	task automatic apply_row(input row_t r);
		case (r.op)
			OP_MODE: {is_gbc, is_gbc_game} = r.data[1:0];
			OP_RST: begin
				reset_ss = 1'b1;
				repeat (4) tick();
				reset_ss = 1'b0;
			end
			OP_WR: begin
				cpu_addr  = r.addr;
				cpu_wdata = r.data;
				cpu_wr_n  = 1'b0;
				tick();              // commit edge
				cpu_wdata = ~r.data; // pulse still held, must not land
				tick();
				cpu_wr_n  = 1'b1;
			end
			OP_RD: begin
				cpu_addr = r.addr;
				@(negedge clk_sys);  // comb path settled
				check("cpu_rdata", 16'(cpu_rdata), r.exp);
			end
			OP_EVT: begin
				evt = r.data[3:0];
				tick();
				evt = 4'h0;
				tick();
			end
			OP_ACK: begin
				cpu_m1_n   = 1'b0;
				cpu_iorq_n = 1'b0;
				@(negedge clk_sys);
				check("cpu_rdata (vector)", 16'(cpu_rdata), r.exp);
				tick();
				cpu_m1_n   = 1'b1;
				cpu_iorq_n = 1'b1;
				tick();              // clear edge
			end
			OP_STOP: begin
				cpu_stop = 1'b1;
				tick();
				cpu_stop = 1'b0;
			end
			OP_JOY: begin
				joy_din = r.data[3:0];
				repeat (3) tick();   // two stage sync plus set
			end
			OP_PORT: begin
				@(negedge clk_sys);
				check("irq_n", 16'(irq_n), 16'(r.exp[8]));
				check("joy_p54", 16'(joy_p54), 16'(r.exp[7:6]));
				check("iram_bank", 16'(iram_bank), 16'(r.exp[5:3]));
				check("vram_bank", 16'(vram_bank), 16'(r.exp[2]));
				check("speed", 16'(speed), 16'(r.exp[1]));
				check("boot_rom_enabled", 16'(boot_rom_enabled), 16'(r.exp[0]));
			end
			default: begin
				errors++;
				$display("unknown operation %0d in the stimulus table", r.op);
			end
		endcase
	endtask

	initial begin
		build_table();
		tick();
		foreach (rows[i]) begin
			apply_row(rows[i]);
			tick();
		end
		$display("rows applied: %0d, errors: %0d", rows.size(), errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// every row fits in 10 clocks
	initial begin
		#1;
		#(rows.size() * 10 * 100);
		$display("timeout: the stimulus table did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: all.f
logic/gb_io_pkg.sv
logic/irq_bus_if.sv
logic/ctrl_bus_if.sv
logic/irq_controller.sv
logic/sys_ctrl_regs.sv
logic/cpu_bus_decode.sv
logic/gb_io_top.sv
sim/tb_gb_io.sv
